//--- design/rvBackend_defs.svh
`ifndef RV_BACKEND_DEFS_SVH
`define RV_BACKEND_DEFS_SVH

// Data path, PC and immediate width.
`define DATA_WIDTH 32

// Register index width, 32 architectural registers.
`define REG_ADDR_WIDTH 5

// Data memory word index width, 64 words.
`define DMEM_ADDR_WIDTH 6

`endif

//--- design/rvBackendPkg.sv
`default_nettype none
`include "rvBackend_defs.svh"

package rvBackendPkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } aluOp_e;

    typedef enum logic [1:0] {
        RES_ALU     = 2'd0,
        RES_LOAD    = 2'd1,
        RES_PCPLUS4 = 2'd2
    } resultSrc_e;

    // Same encoding as the classic forwarding mux select.
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwdSel_e;

    typedef struct packed {
        logic                       regWrite;
        resultSrc_e                 resultSrc;
        logic                       memWrite;
        logic                       jump;
        logic                       branch;
        aluOp_e                     aluControl;
        logic                       aluSrc;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     imm;
        logic [`DATA_WIDTH-1:0]     pc;
        logic [`DATA_WIDTH-1:0]     pcPlus4;
    } issueBundle_t;

    typedef struct packed {
        logic                       regWrite;
        resultSrc_e                 resultSrc;
        logic                       memWrite;
        logic                       jump;
        logic                       branch;
        aluOp_e                     aluControl;
        logic                       aluSrc;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     imm;
        logic [`DATA_WIDTH-1:0]     pc;
        logic [`DATA_WIDTH-1:0]     pcPlus4;
        logic [`DATA_WIDTH-1:0]     rd1;
        logic [`DATA_WIDTH-1:0]     rd2;
    } idExBundle_t;

    typedef struct packed {
        logic                       regWrite;
        resultSrc_e                 resultSrc;
        logic                       memWrite;
        logic [`DATA_WIDTH-1:0]     aluResult;
        logic [`DATA_WIDTH-1:0]     writeData;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     pcPlus4;
    } exMemBundle_t;

    typedef struct packed {
        logic                       regWrite;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     result;
    } memWbBundle_t;

endpackage

`default_nettype wire

//--- design/alu.sv
`default_nettype none
`include "rvBackend_defs.svh"

module alu (
    input  wire logic [`DATA_WIDTH-1:0] srcA,
    input  wire logic [`DATA_WIDTH-1:0] srcB,
    input  wire rvBackendPkg::aluOp_e   aluControl,
    output logic [`DATA_WIDTH-1:0]      result,
    output logic                        zero
);
    import rvBackendPkg::*;

    localparam int shamtWidth = $clog2(`DATA_WIDTH);

    logic [shamtWidth-1:0] shamt;

    // Shift amount comes from the low bits of operand B only.
    assign shamt = srcB[shamtWidth-1:0];

    always_comb begin
        case (aluControl)
            ALU_ADD:  result = srcA + srcB;
            ALU_SUB:  result = srcA - srcB;
            ALU_AND:  result = srcA & srcB;
            ALU_OR:   result = srcA | srcB;
            ALU_XOR:  result = srcA ^ srcB;
            ALU_SLT: begin
                result = '0;
                result[0] = $signed(srcA) < $signed(srcB);
            end
            ALU_SLTU: begin
                result = '0;
                result[0] = srcA < srcB;
            end
            ALU_SLL:  result = srcA << shamt;
            ALU_SRL:  result = srcA >> shamt;
            ALU_SRA:  result = $unsigned($signed(srcA) >>> shamt);
            default:  result = '0;
        endcase
    end

    // Branch equality relies on SUB giving zero.
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- design/forwardUnit.sv
`default_nettype none
`include "rvBackend_defs.svh"

module forwardUnit (
    input  wire logic [`REG_ADDR_WIDTH-1:0] rs1E,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rs2E,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rdM,
    input  wire logic                       regWriteM,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rdW,
    input  wire logic                       regWriteW,
    output rvBackendPkg::fwdSel_e           fwdA,
    output rvBackendPkg::fwdSel_e           fwdB
);
    import rvBackendPkg::*;

    // The younger producer in the memory stage takes priority.
    function automatic fwdSel_e pickSource(input logic [`REG_ADDR_WIDTH-1:0] rs);
        fwdSel_e sel;
        if (regWriteM && (rdM != '0) && (rdM == rs)) begin
            sel = FWD_MEM;
        end else if (regWriteW && (rdW != '0) && (rdW == rs)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = pickSource(rs1E);
        fwdB = pickSource(rs2E);
    end

endmodule

`default_nettype wire

//--- design/registerRead.sv
`default_nettype none
`include "rvBackend_defs.svh"

module registerRead (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire rvBackendPkg::issueBundle_t issue,
    input  wire rvBackendPkg::memWbBundle_t wb,
    output rvBackendPkg::idExBundle_t       idEx
);
    import rvBackendPkg::*;

    localparam int numRegs = 1 << `REG_ADDR_WIDTH;

    logic [`DATA_WIDTH-1:0] regs [0:numRegs-1];
    logic [`DATA_WIDTH-1:0] rd1;
    logic [`DATA_WIDTH-1:0] rd2;
    idExBundle_t            idExNext;

    // Write-first read, a same-cycle writeback wins over the stored value.
    function automatic logic [`DATA_WIDTH-1:0] readPort(
        input logic [`REG_ADDR_WIDTH-1:0] addr
    );
        logic [`DATA_WIDTH-1:0] value;
        if (wb.regWrite && (wb.rd != '0) && (wb.rd == addr)) begin
            value = wb.result;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regWrite && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_comb begin
        rd1 = readPort(issue.rs1);
        rd2 = readPort(issue.rs2);
    end

    always_comb begin
        idExNext.regWrite   = issue.regWrite;
        idExNext.resultSrc  = issue.resultSrc;
        idExNext.memWrite   = issue.memWrite;
        idExNext.jump       = issue.jump;
        idExNext.branch     = issue.branch;
        idExNext.aluControl = issue.aluControl;
        idExNext.aluSrc     = issue.aluSrc;
        idExNext.rs1        = issue.rs1;
        idExNext.rs2        = issue.rs2;
        idExNext.rd         = issue.rd;
        idExNext.imm        = issue.imm;
        idExNext.pc         = issue.pc;
        idExNext.pcPlus4    = issue.pcPlus4;
        idExNext.rd1        = rd1;
        idExNext.rd2        = rd2;
    end

    always_ff @(posedge clk) begin
        idEx <= idExNext;
        if (rst) begin
            idEx.regWrite <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.jump     <= 1'b0;
            idEx.branch   <= 1'b0;
        end
    end

    // The stored x0 entry keeps its zero through a write to x0.
    x0StaysZero: assert property (@(posedge clk) disable iff (rst)
        (wb.regWrite && (wb.rd == '0)) |=> (regs[0] == '0))
        else $error("write to x0 became visible");

endmodule

`default_nettype wire

//--- design/executeStage.sv
`default_nettype none
`include "rvBackend_defs.svh"

module executeStage (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire rvBackendPkg::idExBundle_t  idEx,
    input  wire rvBackendPkg::fwdSel_e      fwdA,
    input  wire rvBackendPkg::fwdSel_e      fwdB,
    input  wire logic [`DATA_WIDTH-1:0]     resultW,
    output rvBackendPkg::exMemBundle_t      exMem,
    output logic                            redirectTaken,
    output logic [`DATA_WIDTH-1:0]          redirectTarget
);
    import rvBackendPkg::*;

    logic [`DATA_WIDTH-1:0] memFwdValue;
    logic [`DATA_WIDTH-1:0] srcA;
    logic [`DATA_WIDTH-1:0] srcB;
    logic [`DATA_WIDTH-1:0] writeData;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic                   zero;
    logic                   usesA;
    logic                   usesB;
    exMemBundle_t           exMemNext;

    function automatic logic [`DATA_WIDTH-1:0] pickOperand(
        input fwdSel_e                sel,
        input logic [`DATA_WIDTH-1:0] regValue,
        input logic [`DATA_WIDTH-1:0] memValue,
        input logic [`DATA_WIDTH-1:0] wbValue
    );
        logic [`DATA_WIDTH-1:0] value;
        case (sel)
            FWD_MEM: value = memValue;
            FWD_WB:  value = wbValue;
            default: value = regValue;
        endcase
        return value;
    endfunction

    // A jump in the memory stage forwards its link address.
    assign memFwdValue = (exMem.resultSrc == RES_PCPLUS4) ? exMem.pcPlus4 : exMem.aluResult;

    always_comb begin
        srcA      = pickOperand(fwdA, idEx.rd1, memFwdValue, resultW);
        writeData = pickOperand(fwdB, idEx.rd2, memFwdValue, resultW);
        srcB      = idEx.aluSrc ? idEx.imm : writeData;
    end

    alu aluInst (
        .srcA       (srcA),
        .srcB       (srcB),
        .aluControl (idEx.aluControl),
        .result     (aluResult),
        .zero       (zero)
    );

    assign redirectTaken  = idEx.jump | (idEx.branch & zero);
    assign redirectTarget = idEx.pc + idEx.imm;

    always_comb begin
        exMemNext.regWrite  = idEx.regWrite;
        exMemNext.resultSrc = idEx.resultSrc;
        exMemNext.memWrite  = idEx.memWrite;
        exMemNext.aluResult = aluResult;
        exMemNext.writeData = writeData;
        exMemNext.rd        = idEx.rd;
        exMemNext.pcPlus4   = idEx.pcPlus4;
    end

    always_ff @(posedge clk) begin
        exMem <= exMemNext;
        if (rst) begin
            exMem.regWrite <= 1'b0;
            exMem.memWrite <= 1'b0;
        end
    end

    // Operand use by instruction class, jumps take their target from pc.
    assign usesA = (idEx.regWrite & ~idEx.jump) | idEx.memWrite | idEx.branch;
    assign usesB = (~idEx.aluSrc & (idEx.regWrite | idEx.branch)) | idEx.memWrite;

    // The front end keeps load consumers out of the slot right after a load.
    noLoadForward: assert property (@(posedge clk) disable iff (rst)
        ((usesA && (fwdA == FWD_MEM)) || (usesB && (fwdB == FWD_MEM))) |->
            (exMem.resultSrc != RES_LOAD))
        else $error("load value forwarded from memory stage");

endmodule

`default_nettype wire

//--- design/memoryStage.sv
`default_nettype none
`include "rvBackend_defs.svh"

module memoryStage (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire rvBackendPkg::exMemBundle_t exMem,
    output rvBackendPkg::memWbBundle_t      memWb
);
    import rvBackendPkg::*;

    localparam int dmemDepth = 1 << `DMEM_ADDR_WIDTH;

    logic [`DATA_WIDTH-1:0]     dmem [0:dmemDepth-1];
    logic [`DMEM_ADDR_WIDTH-1:0] wordAddr;
    logic [`DATA_WIDTH-1:0]     readData;
    logic [`DATA_WIDTH-1:0]     result;
    memWbBundle_t               memWbNext;

    // Word addressed, the two byte offset bits are dropped.
    assign wordAddr = exMem.aluResult[`DMEM_ADDR_WIDTH+1:2];
    assign readData = dmem[wordAddr];

    always_ff @(posedge clk) begin
        if (exMem.memWrite) begin
            dmem[wordAddr] <= exMem.writeData;
        end
    end

    always_comb begin
        case (exMem.resultSrc)
            RES_LOAD:    result = readData;
            RES_PCPLUS4: result = exMem.pcPlus4;
            default:     result = exMem.aluResult;
        endcase
    end

    always_comb begin
        memWbNext.regWrite = exMem.regWrite;
        memWbNext.rd       = exMem.rd;
        memWbNext.result   = result;
    end

    always_ff @(posedge clk) begin
        memWb <= memWbNext;
        if (rst) begin
            memWb.regWrite <= 1'b0;
        end
    end

    // A store never produces a register writeback.
    storeNoWriteback: assert property (@(posedge clk) disable iff (rst)
        exMem.memWrite |=> !memWb.regWrite)
        else $error("store reached writeback with regWrite set");

endmodule

`default_nettype wire

//--- design/rvBackendTop.sv
`default_nettype none
`include "rvBackend_defs.svh"

module rvBackendTop (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire rvBackendPkg::issueBundle_t issue,
    output logic                            redirectTaken,
    output logic [`DATA_WIDTH-1:0]          redirectTarget,
    output logic                            wbValid,
    output logic [`REG_ADDR_WIDTH-1:0]      wbRd,
    output logic [`DATA_WIDTH-1:0]          wbResult
);
    import rvBackendPkg::*;

    idExBundle_t  idEx;
    exMemBundle_t exMem;
    memWbBundle_t memWb;
    fwdSel_e      fwdA;
    fwdSel_e      fwdB;

    registerRead registerReadInst (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .wb    (memWb),
        .idEx  (idEx)
    );

    forwardUnit forwardUnitInst (
        .rs1E      (idEx.rs1),
        .rs2E      (idEx.rs2),
        .rdM       (exMem.rd),
        .regWriteM (exMem.regWrite),
        .rdW       (memWb.rd),
        .regWriteW (memWb.regWrite),
        .fwdA      (fwdA),
        .fwdB      (fwdB)
    );

    executeStage executeStageInst (
        .clk            (clk),
        .rst            (rst),
        .idEx           (idEx),
        .fwdA           (fwdA),
        .fwdB           (fwdB),
        .resultW        (memWb.result),
        .exMem          (exMem),
        .redirectTaken  (redirectTaken),
        .redirectTarget (redirectTarget)
    );

    memoryStage memoryStageInst (
        .clk   (clk),
        .rst   (rst),
        .exMem (exMem),
        .memWb (memWb)
    );

    // Writes to x0 are dropped by the register file and not reported.
    assign wbValid  = memWb.regWrite && (memWb.rd != '0);
    assign wbRd     = memWb.rd;
    assign wbResult = memWb.result;

endmodule

`default_nettype wire

//--- verification/rvBackendTb.sv
`default_nettype none
`include "rvBackend_defs.svh"

module rvBackendTb;
    import rvBackendPkg::*;

    localparam int resetCycles = 16;

    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     value;
    } wbExp_t;

    typedef struct packed {
        int                     cycle;
        logic                   isCtrl;
        logic                   taken;
        logic [`DATA_WIDTH-1:0] target;
    } redirExp_t;

    logic                       clk;
    logic                       rst;
    issueBundle_t               issue;
    logic                       redirectTaken;
    logic [`DATA_WIDTH-1:0]     redirectTarget;
    logic                       wbValid;
    logic [`REG_ADDR_WIDTH-1:0] wbRd;
    logic [`DATA_WIDTH-1:0]     wbResult;

    issueBundle_t           prog[$];
    wbExp_t                 wbQueue[$];
    redirExp_t              redirQueue[$];
    logic [`DATA_WIDTH-1:0] modelRegs[0:31];
    logic [`DATA_WIDTH-1:0] modelMem[0:(1 << `DMEM_ADDR_WIDTH)-1];
    logic [31:0]            rngState = 32'd42203;
    int                     lastRd[0:2] = '{0, 0, 0};
    int                     lastLoadRd = 0;
    int                     cycle = 0;
    int                     limit = 0;
    int                     checks = 0;
    int                     errors = 0;

    rvBackendTop dut_i (
        .clk            (clk),
        .rst            (rst),
        .issue          (issue),
        .redirectTaken  (redirectTaken),
        .redirectTarget (redirectTarget),
        .wbValid        (wbValid),
        .wbRd           (wbRd),
        .wbResult       (wbResult)
    );

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int randomBelow(int span);
        return int'(nextRandom() % span);
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] aluModel(aluOp_e op, logic [`DATA_WIDTH-1:0] a,
                                                       logic [`DATA_WIDTH-1:0] b);
        logic [2*`DATA_WIDTH-1:0] wide;
        logic [`DATA_WIDTH-1:0]   res;
        wide = {{`DATA_WIDTH{a[`DATA_WIDTH-1]}}, a} >> b[4:0];
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            // Signs differ, so the negative one is smaller.
            ALU_SLT:  res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            ALU_SLTU: res = {31'b0, a < b};
            ALU_SLL:  res = a << b[4:0];
            ALU_SRL:  res = a >> b[4:0];
            ALU_SRA:  res = wide[`DATA_WIDTH-1:0];
            default:  res = '0;
        endcase
        return res;
    endfunction

    // Kinds: -1 bubble, 0 ALU register, 1 ALU immediate, 2 load, 3 store, 4 jump, 5 branch.
    function automatic void emit(int kind, aluOp_e op, int rd, int rs1, int rs2,
                                 logic [`DATA_WIDTH-1:0] imm);
        issueBundle_t ins;
        ins = '0;
        if (kind >= 0) begin
            // A load result is not ready for the very next instruction.
            if (lastLoadRd != 0 && rs1 == lastLoadRd) rs1 = 0;
            if (lastLoadRd != 0 && rs2 == lastLoadRd) rs2 = 0;
            ins.regWrite   = kind inside {0, 1, 2, 4};
            ins.aluSrc     = kind inside {1, 2, 3};
            ins.memWrite   = (kind == 3);
            ins.jump       = (kind == 4);
            ins.branch     = (kind == 5);
            ins.resultSrc  = (kind == 2) ? RES_LOAD : ((kind == 4) ? RES_PCPLUS4 : RES_ALU);
            ins.aluControl = (kind <= 1) ? op : ((kind == 5) ? ALU_SUB : ALU_ADD);
            ins.rd         = ins.regWrite ? `REG_ADDR_WIDTH'(rd) : '0;
            ins.rs1        = `REG_ADDR_WIDTH'(rs1);
            ins.rs2        = `REG_ADDR_WIDTH'(rs2);
            ins.imm        = imm;
            ins.pc         = 32'h100 + 32'(4 * prog.size());
            ins.pcPlus4    = ins.pc + 32'd4;
        end
        lastLoadRd = (kind == 2) ? rd : 0;
        lastRd[2] = lastRd[1];
        lastRd[1] = lastRd[0];
        lastRd[0] = int'(ins.rd);
        prog.push_back(ins);
    endfunction

    // Architectural model, one instruction at a time in issue order.
    function automatic void executeModel(issueBundle_t ins, int issueCycle);
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] res;
        redirExp_t              redir;
        a = modelRegs[ins.rs1];
        b = modelRegs[ins.rs2];
        res = aluModel(ins.aluControl, a, ins.aluSrc ? ins.imm : b);
        redir.cycle  = issueCycle + 1;
        redir.isCtrl = ins.jump | ins.branch;
        redir.taken  = ins.jump | (ins.branch & (a == b));
        redir.target = ins.pc + ins.imm;
        redirQueue.push_back(redir);
        if (ins.memWrite) modelMem[res[`DMEM_ADDR_WIDTH+1:2]] = b;
        if (ins.resultSrc == RES_LOAD) res = modelMem[res[`DMEM_ADDR_WIDTH+1:2]];
        if (ins.jump) res = ins.pc + 32'd4;
        if (ins.regWrite && ins.rd != '0) begin
            modelRegs[ins.rd] = res;
            wbQueue.push_back({ins.rd, res});
        end
    endfunction

    function automatic void buildProgram();
        int kind;
        repeat (4) emit(-1, ALU_ADD, 0, 0, 0, '0);
        emit(0, ALU_ADD, 3, 1, 2, '0);
        for (int r = 1; r < 32; r++) emit(1, ALU_ADD, r, 0, 0, nextRandom());
        emit(1, ALU_ADD, 1, 0, 0, 32'h8000_0123);
        // Results go to x16..x31 so the x1..x15 sources stay fixed.
        for (int op = 0; op < 10; op++) begin
            for (int k = 0; k < 6; k++) begin
                emit(k % 2, aluOp_e'(op), 16 + randomBelow(16), 1 + randomBelow(15),
                     1 + randomBelow(15), nextRandom());
            end
        end
        for (int i = 0; i < 60; i++) begin
            emit(randomBelow(2), aluOp_e'(randomBelow(10)),
                 (randomBelow(6) == 0) ? 0 : 1 + randomBelow(7),
                 lastRd[randomBelow(3)], lastRd[randomBelow(3)], nextRandom());
        end
        // Store data comes straight from the previous instruction.
        for (int w = 0; w < 16; w++) begin
            emit(1, ALU_ADD, 8, 0, 0, nextRandom());
            emit(3, ALU_ADD, 0, 0, 8, w * 4);
        end
        for (int w = 0; w < 16; w++) begin
            emit(2, ALU_ADD, 9, 0, 0, w * 4);
            emit(-1, ALU_ADD, 0, 0, 0, '0);
            emit(0, ALU_ADD, 10, 9, 9, '0);
        end
        for (int i = 0; i < 12; i++) begin
            emit(4, ALU_ADD, (i % 3 == 0) ? 0 : 11, 0, 0, nextRandom() & 32'h0000_0ffc);
            emit(5, ALU_SUB, 0, 12, (i % 2 == 0) ? 12 : 13, nextRandom() & 32'h0000_0ffc);
        end
        // Loads and stores stay within the words written above.
        for (int i = 0; i < 400; i++) begin
            kind = randomBelow(6);
            if (kind == 2 || kind == 3) begin
                emit(kind, ALU_ADD, randomBelow(16), 0, randomBelow(16), 4 * randomBelow(16));
            end else begin
                emit(kind, aluOp_e'(randomBelow(10)), randomBelow(16), randomBelow(16),
                     randomBelow(16), nextRandom());
            end
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst   = 1'b1;
        issue = '0;
        foreach (modelRegs[r]) modelRegs[r] = '0;
        buildProgram();
        limit = resetCycles + prog.size() + 40;
        repeat (resetCycles) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (prog[i]) begin
            executeModel(prog[i], cycle);
            issue = prog[i];
            @(posedge clk);
            #2;
        end
        issue = '0;
        while (wbQueue.size() != 0 || redirQueue.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Outputs are sampled mid-cycle, away from the driving edge.
    always @(negedge clk) begin
        redirExp_t redir;
        wbExp_t    wb;
        if (!rst && redirQueue.size() != 0 && redirQueue[0].cycle == cycle) begin
            redir = redirQueue.pop_front();
            checks++;
            assert (redirectTaken == redir.taken &&
                    (!redir.isCtrl || redirectTarget == redir.target))
                else begin
                    errors++;
                    $display("** Error at %0t: redirect %b %h, expected %b %h", $time,
                             redirectTaken, redirectTarget, redir.taken, redir.target);
                end
        end
        if (!rst && wbValid) begin
            if (wbQueue.size() == 0) begin
                errors++;
                $display("Writeback to x%0d at time %0t was not expected", wbRd, $time);
            end else begin
                wb = wbQueue.pop_front();
                checks++;
                assert (wbRd == wb.rd && wbResult == wb.value)
                    else begin
                        errors++;
                        $display("** Error at %0t: writeback x%0d = %h, expected x%0d = %h",
                                 $time, wbRd, wbResult, wb.rd, wb.value);
                    end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("Run stopped at cycle %0d with %0d expected writebacks never seen",
                     cycle, wbQueue.size());
            $display("Some tests failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/rvBackendPkg.sv
design/alu.sv
design/forwardUnit.sv
design/registerRead.sv
design/executeStage.sv
design/memoryStage.sv
design/rvBackendTop.sv
verification/rvBackendTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the backend testbench with Verilator.

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -f filelist.f --top-module rvBackendTb \
    -Mdir obj_dir -o rvBackendSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rvBackendSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "All tests passed" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1
